//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// direct-mapped geometry, tag + index + offset must stay at 16 bits
`define CACHE_SETS 8
`define CACHE_INDEX_BITS 3

// byte offset inside one line
`define CACHE_OFFSET_BITS 4

`define CACHE_TAG_BITS 9

// one memory transfer moves a whole line
`define CACHE_LINE_BITS 128
`define CACHE_WORDS_PER_LINE 8

`endif

//--- lc3b_types.sv
`default_nettype none

`include "cache_defines.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;

    // one enable bit per byte, bit 0 is the low byte
    typedef logic [1:0] lc3b_mem_wmask;

    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0] tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [`CACHE_OFFSET_BITS-1:0] offset;
    } lc3b_addr_fields_t;

    // the same address seen as a flat word or split for the cache
    typedef union packed {
        lc3b_word word;
        lc3b_addr_fields_t fields;
    } lc3b_addr_u;

endpackage : lc3b_types

`default_nettype wire

//--- cache_types.sv
`default_nettype none

`include "cache_defines.svh"

package cache_types;
    import lc3b_types::*;

    typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;

    // cpu side, one word per access
    typedef struct packed {
        lc3b_addr_u addr;
        logic write;
        lc3b_word wdata;
        lc3b_mem_wmask wmask;
    } cpu_req_t;

    // memory side, line address has a zero offset
    typedef struct packed {
        lc3b_word addr;
        logic we;
        cache_line_t wdata;
    } mem_req_t;

endpackage : cache_types

`default_nettype wire

//--- cache_control.sv
`timescale 1ns/1ns
`default_nettype none

module cache_control (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic cpu_strobe,
    input  wire logic cpu_write,
    input  wire logic hit,
    input  wire logic need_writeback,
    input  wire logic mem_resp,
    output logic cpu_resp,
    output logic hit_write,
    output logic ctrl_write,
    output logic ctrl_reload,
    output logic mem_strobe,
    output logic mem_we
);

    typedef enum logic [2:0] {
        RW_HIT,
        LOAD_ADDR,
        WRITE_BACK,
        MEM_RESET,
        RELOAD
    } state_t;

    state_t state;
    state_t next_state;

    always_comb begin
        cpu_resp = 1'b0;
        hit_write = 1'b0;
        ctrl_write = 1'b0;
        ctrl_reload = 1'b0;
        mem_strobe = 1'b0;
        mem_we = 1'b0;
        case (state)
            RW_HIT: begin
                cpu_resp = cpu_strobe && hit;
                hit_write = cpu_strobe && hit && cpu_write;
            end
            // stored tag drives the memory address one cycle early
            LOAD_ADDR: begin
                ctrl_write = 1'b1;
            end
            WRITE_BACK: begin
                ctrl_write = 1'b1;
                mem_strobe = 1'b1;
                mem_we = 1'b1;
            end
            // strobe drops for a cycle between the two transfers
            MEM_RESET: begin
            end
            RELOAD: begin
                ctrl_reload = 1'b1;
                mem_strobe = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            RW_HIT: begin
                if (cpu_strobe && !hit) begin
                    next_state = need_writeback ? LOAD_ADDR : MEM_RESET;
                end
            end
            LOAD_ADDR: next_state = WRITE_BACK;
            WRITE_BACK: begin
                if (mem_resp) begin
                    next_state = MEM_RESET;
                end
            end
            MEM_RESET: next_state = RELOAD;
            RELOAD: begin
                // line is written this cycle, the retry then hits
                if (mem_resp) begin
                    next_state = RW_HIT;
                end
            end
            default: next_state = RW_HIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RW_HIT;
        end else begin
            state <= next_state;
        end
    end

    a_we_needs_strobe: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> mem_strobe);

    a_miss_leaves_hit: assert property (@(posedge clk) disable iff (reset)
        (state == RW_HIT && cpu_strobe && !hit) |=> (state != RW_HIT));

endmodule : cache_control

`default_nettype wire

//--- cache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_datapath
    import lc3b_types::*, cache_types::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire cpu_req_t cpu_req,
    input  wire logic hit_write,
    input  wire logic ctrl_write,
    input  wire logic ctrl_reload,
    input  wire logic mem_resp,
    input  wire cache_line_t mem_rdata,
    output logic hit,
    output logic need_writeback,
    output lc3b_word cpu_rdata,
    output lc3b_word mem_addr,
    output cache_line_t mem_wdata
);

    localparam int WORD_SEL_BITS = $clog2(`CACHE_WORDS_PER_LINE);

    logic [`CACHE_TAG_BITS-1:0] tag_array [`CACHE_SETS];
    cache_line_t data_array [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_bits;
    logic [`CACHE_SETS-1:0] dirty_bits;

    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [`CACHE_TAG_BITS-1:0] stored_tag;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic tag_match;
    logic reload_write;
    cache_line_t cur_line;
    cache_line_t merged_line;
    lc3b_addr_u line_addr;

    assign index = cpu_req.addr.fields.index;
    assign word_sel = cpu_req.addr.fields.offset[`CACHE_OFFSET_BITS-1:1];
    assign stored_tag = tag_array[index];
    assign cur_line = data_array[index];

    assign tag_match = (stored_tag == cpu_req.addr.fields.tag);
    assign hit = valid_bits[index] && tag_match;
    assign need_writeback = valid_bits[index] && dirty_bits[index] && !tag_match;
    assign reload_write = ctrl_reload && mem_resp;

    assign cpu_rdata = cur_line[word_sel*16 +: 16];
    assign mem_wdata = cur_line;

    // victim address during write-back, requested line otherwise
    always_comb begin
        line_addr.fields.tag = ctrl_write ? stored_tag : cpu_req.addr.fields.tag;
        line_addr.fields.index = index;
        line_addr.fields.offset = '0;
    end

    assign mem_addr = line_addr.word;

    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < 2; b++) begin
            if (cpu_req.wmask[b]) begin
                merged_line[word_sel*16 + b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            data_array[index] <= merged_line;
        end else if (reload_write) begin
            data_array[index] <= mem_rdata;
            tag_array[index] <= cpu_req.addr.fields.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (hit_write) begin
            dirty_bits[index] <= 1'b1;
        end else if (reload_write) begin
            // fresh line from memory is clean
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
        end
    end

    a_no_write_overlap: assert property (@(posedge clk) disable iff (reset)
        !(hit_write && reload_write));

endmodule : cache_datapath

`default_nettype wire

//--- cache.sv
`timescale 1ns/1ns
`default_nettype none

module cache
    import lc3b_types::*, cache_types::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic cpu_strobe,
    input  wire cpu_req_t cpu_req,
    output logic cpu_resp,
    output lc3b_word cpu_rdata,
    output logic mem_strobe,
    output mem_req_t mem_req,
    input  wire logic mem_resp,
    input  wire cache_line_t mem_rdata
);

    logic hit;
    logic need_writeback;
    logic hit_write;
    logic ctrl_write;
    logic ctrl_reload;
    logic mem_we;
    lc3b_word mem_addr;
    cache_line_t mem_wdata;

    cache_control u_control (
        .clk            (clk),
        .reset          (reset),
        .cpu_strobe     (cpu_strobe),
        .cpu_write      (cpu_req.write),
        .hit            (hit),
        .need_writeback (need_writeback),
        .mem_resp       (mem_resp),
        .cpu_resp       (cpu_resp),
        .hit_write      (hit_write),
        .ctrl_write     (ctrl_write),
        .ctrl_reload    (ctrl_reload),
        .mem_strobe     (mem_strobe),
        .mem_we         (mem_we)
    );

    cache_datapath u_datapath (
        .clk            (clk),
        .reset          (reset),
        .cpu_req        (cpu_req),
        .hit_write      (hit_write),
        .ctrl_write     (ctrl_write),
        .ctrl_reload    (ctrl_reload),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata),
        .hit            (hit),
        .need_writeback (need_writeback),
        .cpu_rdata      (cpu_rdata),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    // line-wide memory request
    assign mem_req.addr = mem_addr;
    assign mem_req.we = mem_we;
    assign mem_req.wdata = mem_wdata;

endmodule : cache

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset drops just after a rising edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- tb_main_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module tb_main_memory
    import cache_types::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic mem_strobe,
    input  wire mem_req_t mem_req,
    output logic mem_resp,
    output cache_line_t mem_rdata
);

    localparam int LINE_ADDR_BITS = 16 - `CACHE_OFFSET_BITS;
    localparam int LINES = 1 << LINE_ADDR_BITS;

    cache_line_t image [LINES];
    logic [31:0] lfsr_state;
    logic [3:0] delay;

    // every word holds a scrambled copy of its own word address
    function automatic logic [15:0] fill_word(input logic [14:0] word_addr);
        logic [31:0] product;
        product = {17'b0, word_addr} * 32'h0000_9e37;
        return product[15:0] ^ 16'h5a5a;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    initial begin
        cache_line_t fill_line;
        for (int l = 0; l < LINES; l++) begin
            fill_line = '0;
            for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
                fill_line = {fill_word(15'(l * `CACHE_WORDS_PER_LINE + w)),
                             fill_line[`CACHE_LINE_BITS-1:16]};
            end
            image[LINE_ADDR_BITS'(l)] = fill_line;
        end
    end

    // one transfer at a time, 1 to 8 cycles of latency each
    initial begin
        mem_resp = 1'b0;
        mem_rdata = '0;
        delay = 4'd0;
        lfsr_state = 32'h60d3;
        forever begin
            @(posedge clk);
            #1;
            if (mem_resp) begin
                mem_resp = 1'b0;
            end else if (!reset && mem_strobe) begin
                if (delay == 4'd0) begin
                    delay = 4'(random_bits(3)) + 4'd1;
                end
                delay = delay - 4'd1;
                if (delay == 4'd0) begin
                    if (mem_req.we) begin
                        image[mem_req.addr[15:`CACHE_OFFSET_BITS]] = mem_req.wdata;
                    end else begin
                        mem_rdata = image[mem_req.addr[15:`CACHE_OFFSET_BITS]];
                    end
                    mem_resp = 1'b1;
                end
            end
        end
    end

endmodule : tb_main_memory

`default_nettype wire

//--- tb_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module tb_cache
    import lc3b_types::*, cache_types::*;
();

    localparam int ACCESS_TIMEOUT = 100;
    localparam int WORD_BITS = `CACHE_OFFSET_BITS - 1;

    logic clk;
    logic reset;
    logic cpu_strobe;
    cpu_req_t cpu_req;
    logic cpu_resp;
    lc3b_word cpu_rdata;
    logic mem_strobe;
    mem_req_t mem_req;
    logic mem_resp;
    cache_line_t mem_rdata;

    lc3b_word shadow [32768];
    logic [31:0] lfsr_state;
    string test_name;
    int error_count;
    int timeout_count;
    int strobe_cycles;
    logic aborted;
    logic strobe_prev;
    logic resp_prev;
    mem_req_t req_prev;
    logic xfer_we [$];
    lc3b_word xfer_addr [$];
    cache_line_t xfer_data [$];

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    cache UUT (
        .clk        (clk),
        .reset      (reset),
        .cpu_strobe (cpu_strobe),
        .cpu_req    (cpu_req),
        .cpu_resp   (cpu_resp),
        .cpu_rdata  (cpu_rdata),
        .mem_strobe (mem_strobe),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata)
    );

    tb_main_memory main_memory (
        .clk        (clk),
        .reset      (reset),
        .mem_strobe (mem_strobe),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata)
    );

    // preloaded image content, a scrambled copy of the word address
    function automatic lc3b_word image_word(input logic [14:0] word_addr);
        logic [31:0] product;
        product = {17'b0, word_addr} * 32'h0000_9e37;
        return product[15:0] ^ 16'h5a5a;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // expected word of a completed access, writes merge into the shadow
    function automatic lc3b_word reference_access(input cpu_req_t req);
        lc3b_word word;
        word = shadow[req.addr.word[15:1]];
        if (req.write) begin
            if (req.wmask[0]) begin
                word[7:0] = req.wdata[7:0];
            end
            if (req.wmask[1]) begin
                word[15:8] = req.wdata[15:8];
            end
            shadow[req.addr.word[15:1]] = word;
        end
        return word;
    endfunction

    function automatic cache_line_t shadow_line(input lc3b_word line_addr);
        cache_line_t line;
        line = '0;
        for (int w = `CACHE_WORDS_PER_LINE - 1; w >= 0; w--) begin
            line = {line[`CACHE_LINE_BITS-17:0],
                    shadow[{line_addr[15:`CACHE_OFFSET_BITS], WORD_BITS'(w)}]};
        end
        return line;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] expected,
            input logic [127:0] actual);
        error_count++;
        $display("CHECK FAILED %s (%s): expected %0h, actual %0h",
                 test_name, what, expected, actual);
    endtask

    task automatic clear_log();
        xfer_we.delete();
        xfer_addr.delete();
        xfer_data.delete();
        strobe_cycles = 0;
    endtask

    task automatic expect_transfer(input int idx, input logic we, input lc3b_word addr);
        if (idx >= xfer_we.size()) begin
            error_count++;
            $display("%s: memory transfer %0d never happened", test_name, idx);
        end else begin
            if (xfer_we[idx] !== we) begin
                report_mismatch("transfer write flag", 128'(we), 128'(xfer_we[idx]));
            end
            if (xfer_addr[idx] !== addr) begin
                report_mismatch("transfer address", 128'(addr), 128'(xfer_addr[idx]));
            end
        end
    endtask

    // starts just after a rising edge and returns just after the completing one
    task automatic access(input logic write, input lc3b_word addr, input lc3b_word wdata,
            input lc3b_mem_wmask wmask);
        int cycles;
        logic done;
        if (!aborted) begin
            cpu_req.addr.word = addr;
            cpu_req.write = write;
            cpu_req.wdata = wdata;
            cpu_req.wmask = wmask;
            cpu_strobe = 1'b1;
            cycles = 0;
            done = 1'b0;
            while (!done && cycles < ACCESS_TIMEOUT) begin
                @(negedge clk);
                done = cpu_resp;
                cycles++;
            end
            @(posedge clk);
            #1;
            cpu_strobe = 1'b0;
            if (!done) begin
                timeout_count++;
                aborted = 1'b1;
                $display("%s: no cpu_resp within %0d cycles for address %h",
                         test_name, ACCESS_TIMEOUT, addr);
            end
        end
    endtask

    // read data compare, mid-cycle where the combinational outputs are settled
    always @(negedge clk) begin
        lc3b_word expected;
        if (!reset && cpu_strobe && cpu_resp) begin
            expected = reference_access(cpu_req);
            if (!cpu_req.write && cpu_rdata !== expected) begin
                report_mismatch("read data", 128'(expected), 128'(cpu_rdata));
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (mem_strobe) begin
                strobe_cycles++;
            end
            if (mem_strobe && strobe_prev && !resp_prev && mem_req !== req_prev) begin
                error_count++;
                $display("%s: memory request changed while mem_strobe was held", test_name);
            end
            if (mem_strobe && mem_resp) begin
                xfer_we.push_back(mem_req.we);
                xfer_addr.push_back(mem_req.addr);
                xfer_data.push_back(mem_req.wdata);
            end
        end
        strobe_prev = mem_strobe;
        resp_prev = mem_resp;
        req_prev = mem_req;
    end

    initial begin
        int cycles;
        lc3b_addr_u rand_addr;
        logic rand_write;
        lc3b_mem_wmask rand_mask;
        lc3b_word rand_data;
        cpu_strobe = 1'b0;
        cpu_req = '0;
        error_count = 0;
        timeout_count = 0;
        strobe_cycles = 0;
        aborted = 1'b0;
        strobe_prev = 1'b0;
        lfsr_state = 32'h60d3;
        test_name = "reset";
        for (int i = 0; i < 32768; i++) begin
            shadow[15'(i)] = image_word(15'(i));
        end

        cycles = 0;
        while (reset !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            timeout_count++;
            aborted = 1'b1;
            $display("reset never released");
        end
        if (cpu_resp !== 1'b0) begin
            report_mismatch("cpu_resp after reset", 128'(0), 128'(cpu_resp));
        end
        if (mem_strobe !== 1'b0) begin
            report_mismatch("mem_strobe after reset", 128'(0), 128'(mem_strobe));
        end
        @(posedge clk);
        #1;

        test_name = "first read";
        clear_log();
        access(1'b0, 16'h1234, 16'h0000, 2'b00);
        if (xfer_we.size() != 1) begin
            report_mismatch("memory transfers", 128'(1), 128'(xfer_we.size()));
        end
        expect_transfer(0, 1'b0, 16'h1230);

        test_name = "same line read";
        clear_log();
        access(1'b0, 16'h123e, 16'h0000, 2'b00);
        if (strobe_cycles != 0) begin
            report_mismatch("mem_strobe cycles", 128'(0), 128'(strobe_cycles));
        end

        test_name = "byte enables";
        for (int m = 0; m < 4; m++) begin
            access(1'b1, 16'h1236, 16'ha55a ^ {4{4'(m)}}, 2'(m));
            access(1'b0, 16'h1236, 16'h0000, 2'b00);
        end

        // same index 5, tags 8 and 0x48
        test_name = "write back";
        access(1'b1, 16'h0452, 16'h7e81, 2'b11);
        clear_log();
        access(1'b0, 16'h2452, 16'h0000, 2'b00);
        if (xfer_we.size() != 2) begin
            report_mismatch("memory transfers", 128'(2), 128'(xfer_we.size()));
        end
        expect_transfer(0, 1'b1, 16'h0450);
        expect_transfer(1, 1'b0, 16'h2450);
        if (xfer_data.size() > 0 && xfer_data[0] !== shadow_line(16'h0450)) begin
            report_mismatch("write-back line", shadow_line(16'h0450), xfer_data[0]);
        end

        // four tags over two sets keep evicting each other
        test_name = "random mix";
        for (int n = 0; n < 300 && !aborted; n++) begin
            rand_addr.word = '0;
            rand_addr.fields.tag = `CACHE_TAG_BITS'(random_bits(2)) + `CACHE_TAG_BITS'(12);
            rand_addr.fields.index = `CACHE_INDEX_BITS'(random_bits(1)) + `CACHE_INDEX_BITS'(2);
            rand_addr.fields.offset = {WORD_BITS'(random_bits(WORD_BITS)), 1'b0};
            rand_write = 1'(random_bits(1));
            rand_mask = 2'(random_bits(2));
            rand_data = 16'(random_bits(16));
            access(rand_write, rand_addr.word, rand_data, rand_mask);
        end

        $display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_cache

`default_nettype wire

//--- compile.f
+incdir+.
lc3b_types.sv
cache_types.sv
cache_control.sv
cache_datapath.sv
cache.sv
tb_clock_gen.sv
tb_main_memory.sv
tb_cache.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cache
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --timing --assert
BUILD_FLAGS ?= -j 0
PASS_MESSAGE ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) $(BUILD_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
sim: build
	@output="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF "$(PASS_MESSAGE)"

clean:
	rm -rf $(OBJ_DIR)
